// File: Makefile
# Verilator flow for the flash tester

TOP = flash_tester_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: flist.f
verilog/flash_tester_pkg.sv
verilog/mode_control.sv
verilog/init_sequencer.sv
verilog/access_sequencer.sv
verilog/flash_cmd_port.sv
verilog/flash_tester_top.sv
sim/flash_model.sv
sim/flash_tester_tb.sv

// File: sim/flash_model.sv
`default_nettype none

module flash_model
(
   input  logic                          clock,
   input  logic                          reset,
   input  flash_tester_pkg::flash_op_t   fop,
   input  flash_tester_pkg::flash_addr_t faddress,
   input  flash_tester_pkg::flash_data_t fwdata,
   input  logic [1:0]                    wait_count,
   input  logic                          bad_id,
   input  logic [7:0]                    fault_block,
   output logic                          fbusy,
   output flash_tester_pkg::flash_data_t frdata
);

   import flash_tester_pkg::*;

   typedef enum logic [1:0]
   {
      RM_ARRAY,
      RM_ID,
      RM_STATUS
   } read_mode_t;

   read_mode_t  read_mode;
   flash_data_t pending;                       // First write of a two-write command
   flash_data_t mem [flash_addr_t];            // Only programmed words are stored
   logic [40:0] log_q [$];                     // {op, address, write data}
   logic [1:0]  busy_left;
   logic [1:0]  polls_left;
   logic        sr_fault;

   assign fbusy = (busy_left != 2'd0);

   function automatic int log_size();
      return log_q.size();
   endfunction

   function automatic logic [40:0] log_entry(input int idx);
      return log_q[idx];
   endfunction

   function automatic flash_data_t read_word(input flash_addr_t addr);
      return mem.exists(addr) ? mem[addr] : 16'hFFFF;   // Erased state
   endfunction

   task automatic erase_block(input flash_addr_t addr);
      flash_addr_t keys [$];
      foreach (mem[k])
         if (k[22:16] == addr[22:16])
            keys.push_back(k);
      foreach (keys[i])
         mem.delete(keys[i]);
   endtask

   ////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////

   always @(posedge clock)
   begin
      if (reset)
      begin
         read_mode  <= RM_ARRAY;
         pending    <= '0;
         busy_left  <= '0;
         polls_left <= '0;
         sr_fault   <= 1'b0;
         frdata     <= '0;
      end
      else if (fop == FOP_WRITE)
      begin
         log_q.push_back({fop, faddress, fwdata});
         busy_left <= wait_count;
         pending   <= '0;
         if ((pending == CMD_PROGRAM) ||
             ((pending != 16'h0000) && (fwdata == CMD_CONFIRM)))
         begin
            read_mode  <= RM_STATUS;
            polls_left <= wait_count;          // Reads before the ready bit shows
            sr_fault   <= (pending == CMD_ERASE) && ({1'b0, faddress[22:16]} == fault_block);
            if (pending == CMD_PROGRAM)
               mem[faddress] = fwdata;
            if (pending == CMD_ERASE)
               erase_block(faddress);
         end
         else
         begin
            case (fwdata)
               CMD_READ_ID:    read_mode <= RM_ID;
               CMD_READ_ARRAY: read_mode <= RM_ARRAY;
               CMD_PROGRAM, CMD_ERASE, CMD_CLEAR_LOCKS:
               begin
                  pending   <= fwdata;
                  read_mode <= RM_STATUS;
               end
               default: ;
            endcase
         end
      end
      else if (fop == FOP_READ)
      begin
         log_q.push_back({fop, faddress, 16'h0000});
         busy_left <= wait_count;
         case (read_mode)
            RM_ID:
               frdata <= faddress[0] ? ID_DEVICE_SIZE :
                         (bad_id ? 16'h00B0 : ID_MANUFACTURER);
            RM_STATUS:
               if (polls_left != 2'd0)
               begin
                  frdata     <= 16'h0000;      // Write machine still running
                  polls_left <= polls_left - 2'd1;
               end
               else
                  frdata <= 16'h0080 | (sr_fault ? 16'h0020 : 16'h0000);
            default:
               frdata <= read_word(faddress);
         endcase
      end
      else if (busy_left != 2'd0)
         busy_left <= busy_left - 2'd1;
   end

endmodule

`default_nettype wire

// File: sim/flash_tester_tb.sv
`default_nettype none

module flash_tester_tb;

   import flash_tester_pkg::*;

   localparam int WAIT_LIMIT  = 4000;          // Cycles per wait loop
   localparam int BLOCK_COUNT = 33;

   logic        clock;
   logic        reset;
   mode_t       mode;
   flash_data_t datain;
   flash_addr_t addrin;
   logic        fbusy;
   flash_data_t frdata;
   flash_op_t   fop;
   flash_addr_t faddress;
   flash_data_t fwdata;
   logic        busy;
   status_t     status;

   logic [1:0]  wait_count;
   logic        bad_id;
   logic [7:0]  fault_block;                  // 8'hFF means no erase fault

   logic [31:0] rand_state;
   flash_data_t written [3];
   logic [38:0] logged_writes [$];            // {address, data}

   always #20 clock = ~clock;

   flash_tester_top dut
   (
      .clock    (clock),
      .reset    (reset),
      .mode     (mode),
      .datain   (datain),
      .addrin   (addrin),
      .fbusy    (fbusy),
      .frdata   (frdata),
      .fop      (fop),
      .faddress (faddress),
      .fwdata   (fwdata),
      .busy     (busy),
      .status   (status)
   );

   flash_model flash
   (
      .clock       (clock),
      .reset       (reset),
      .fop         (fop),
      .faddress    (faddress),
      .fwdata      (fwdata),
      .wait_count  (wait_count),
      .bad_id      (bad_id),
      .fault_block (fault_block),
      .fbusy       (fbusy),
      .frdata      (frdata)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
   endtask

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while ((busy !== 1'b0) && (cycles < WAIT_LIMIT))
      begin
         @(negedge clock);
         cycles++;
      end
      if (busy !== 1'b0)
         stop_with_failure("timeout while waiting for busy to fall");
   endtask

   task automatic wait_status(input status_t expected);
      int cycles;
      cycles = 0;
      while ((status !== expected) && (cycles < WAIT_LIMIT))
      begin
         @(negedge clock);
         cycles++;
      end
      if (status !== expected)
         stop_with_failure("timeout while waiting for the error status code");
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      mode  = MODE_IDLE;
      repeat (2) @(negedge clock);
      check_value("fop", 32'(fop), 32'(FOP_IDLE));
      check_value("busy", 32'(busy), 32'd1);
      check_value("status", 32'(status), 32'(ST_RESET));
      reset = 1'b0;
   endtask

   // One-cycle mode request from home with a new flash latency
   task automatic run_mode(input mode_t m);
      logic [31:0] rnd;
      wait_idle();
      rnd        = next_random();
      wait_count = rnd[17:16];
      mode       = m;
      @(negedge clock);
      mode = MODE_IDLE;
   endtask

   task automatic gather_writes(input int first);
      logic [40:0] entry;
      logged_writes.delete();
      for (int i = first; i < flash.log_size(); i++)
      begin
         entry = flash.log_entry(i);
         if (entry[40:39] == FOP_WRITE)
            logged_writes.push_back(entry[38:0]);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic reset_behaviour();
      apply_reset();
      wait_idle();
      check_value("status", 32'(status), 32'(ST_RESET));
      check_value("fop", 32'(fop), 32'(FOP_IDLE));
   endtask

   task automatic init_runs();
      int          first;
      flash_addr_t block;
      first = flash.log_size();
      run_mode(MODE_INIT);
      wait_idle();
      gather_writes(first);
      check_value("write op count", 32'(logged_writes.size()), 32'(4 + 2 * BLOCK_COUNT));
      check_value("fwdata", 32'(logged_writes[0][15:0]), 32'(CMD_READ_ID));
      check_value("fwdata", 32'(logged_writes[1][15:0]), 32'(CMD_READ_ARRAY));
      check_value("fwdata", 32'(logged_writes[2][15:0]), 32'(CMD_CLEAR_LOCKS));
      check_value("fwdata", 32'(logged_writes[3][15:0]), 32'(CMD_CONFIRM));
      for (int b = 0; b < BLOCK_COUNT; b++)
      begin
         block = flash_addr_t'(b) * BLOCK_SIZE;
         check_value("faddress", 32'(logged_writes[4 + 2 * b][38:16]), 32'(block));
         check_value("fwdata", 32'(logged_writes[4 + 2 * b][15:0]), 32'(CMD_ERASE));
         check_value("faddress", 32'(logged_writes[5 + 2 * b][38:16]), 32'(block));
         check_value("fwdata", 32'(logged_writes[5 + 2 * b][15:0]), 32'(CMD_CONFIRM));
      end
      check_value("status", 32'(status), 32'(ST_ERASING));
      check_value("busy", 32'(busy), 32'd0);
   endtask

   task automatic writes_program_words();
      logic [31:0] rnd;
      for (int i = 0; i < 3; i++)
      begin
         rnd        = next_random();
         written[i] = rnd[31:16];
         datain     = written[i];
         run_mode(MODE_WRITE);
         wait_idle();
         check_value("status", 32'(status), 32'(ST_WRITING));
      end
      for (int i = 0; i < 3; i++)
         check_value("flash word", 32'(flash.read_word(flash_addr_t'(i))), 32'(written[i]));
   endtask

   task automatic reads_use_array();
      int          first;
      logic [40:0] entry;
      first  = flash.log_size();
      addrin = 23'd1;
      run_mode(MODE_READ);
      wait_idle();
      check_value("op count", 32'(flash.log_size() - first), 32'd2);
      entry = flash.log_entry(first);
      check_value("fop", 32'(entry[40:39]), 32'(FOP_WRITE));
      check_value("faddress", 32'(entry[38:16]), 32'd0);
      check_value("fwdata", 32'(entry[15:0]), 32'(CMD_READ_ARRAY));
      entry = flash.log_entry(first + 1);
      check_value("fop", 32'(entry[40:39]), 32'(FOP_READ));
      check_value("faddress", 32'(entry[38:16]), 32'(addrin));
      check_value("frdata", 32'(frdata), 32'(written[1]));
      check_value("status", 32'(status), 32'(ST_READING));

      // Array mode already set so only the read itself goes out
      first  = flash.log_size();
      addrin = 23'd2;
      run_mode(MODE_READ);
      wait_idle();
      check_value("op count", 32'(flash.log_size() - first), 32'd1);
      entry = flash.log_entry(first);
      check_value("fop", 32'(entry[40:39]), 32'(FOP_READ));
      check_value("faddress", 32'(entry[38:16]), 32'(addrin));
      check_value("frdata", 32'(frdata), 32'(written[2]));
      check_value("status", 32'(status), 32'(ST_READING));
   endtask

   task automatic bad_id_halts();
      apply_reset();
      bad_id = 1'b1;
      run_mode(MODE_INIT);
      wait_status(ST_BAD_MANUFACTURER);
      repeat (10) @(negedge clock);
      check_value("status", 32'(status), 32'(ST_BAD_MANUFACTURER));
      check_value("busy", 32'(busy), 32'd1);
      bad_id = 1'b0;
   endtask

   task automatic erase_fault_halts();
      int first;
      int settled;
      apply_reset();
      fault_block = 8'd2;                      // Third block
      first       = flash.log_size();
      run_mode(MODE_INIT);
      wait_status(ST_ERASE_BLOCK_ERROR);
      settled = flash.log_size();
      repeat (20) @(negedge clock);
      check_value("ops after error", 32'(flash.log_size() - settled), 32'd0);
      check_value("busy", 32'(busy), 32'd1);
      gather_writes(first);
      check_value("write op count", 32'(logged_writes.size()), 32'd10);
      check_value("faddress", 32'(logged_writes[9][38:16]), 32'(BLOCK_SIZE * 23'd2));
      check_value("fwdata", 32'(logged_writes[9][15:0]), 32'(CMD_CONFIRM));
      fault_block = 8'hFF;
   endtask

   initial
   begin
      clock       = 1'b0;
      reset       = 1'b1;
      mode        = MODE_IDLE;
      datain      = '0;
      addrin      = '0;
      wait_count  = 2'd0;
      bad_id      = 1'b0;
      fault_block = 8'hFF;
      rand_state  = 32'ha016;

      reset_behaviour();
      init_runs();
      writes_program_words();
      reads_use_array();
      bad_id_halts();
      erase_fault_halts();

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/access_sequencer.sv
`default_nettype none

module access_sequencer
(
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          write_start,
   input  logic                          read_start,
   input  logic                          read_armed,
   input  logic                          erase_done,
   input  logic                          port_ready,
   input  flash_tester_pkg::flash_data_t datain,
   input  flash_tester_pkg::flash_addr_t addrin,
   input  flash_tester_pkg::flash_data_t frdata,
   output logic                          op_req,
   output flash_tester_pkg::flash_op_t   op_kind,
   output flash_tester_pkg::flash_addr_t op_addr,
   output flash_tester_pkg::flash_data_t op_wdata,
   output flash_tester_pkg::status_t     phase_code,
   output logic                          access_done,
   output logic                          seq_error,
   output flash_tester_pkg::status_t     err_code
);

   import flash_tester_pkg::*;

   typedef enum logic [2:0]
   {
      AS_IDLE, AS_PROG_CMD, AS_PROG_DATA, AS_PROG_POLL, AS_PROG_CHECK,
      AS_READ_CMD, AS_READ_WORD, AS_ERROR
   } access_state_t;

   access_state_t state;
   flash_addr_t   wptr;                          // Next word to program
   flash_data_t   data_q;
   logic [1:0]    cmd_kind;
   flash_data_t   cmd_wdata;
   flash_addr_t   cmd_addr;
   logic          sr_ready;
   logic          checking;
   logic          hold;
   logic          fail;

   assign sr_ready  = frdata[SR_READY_BIT];
   assign checking  = (state == AS_PROG_CHECK);
   assign hold      = checking && !sr_ready;
   assign fail      = port_ready && checking && sr_ready &&
                      ((|frdata[SR_ERR_HI:SR_ERR_LO]) || (wptr == LAST_ADDR));
   assign seq_error = (state == AS_ERROR);
   assign err_code  = seq_error ? ST_WRITE_ERROR : ST_RESET;

   always_comb
   begin
      case (state)
         AS_PROG_CMD:   {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_PROGRAM, wptr};
         AS_PROG_DATA:  {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, data_q, wptr};
         AS_PROG_POLL,
         AS_PROG_CHECK: {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, wptr};
         AS_READ_CMD:   {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_READ_ARRAY, 23'h0};
         AS_READ_WORD:  {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, addrin};
         default:       {cmd_kind, cmd_wdata, cmd_addr} = {FOP_IDLE, 16'h0, 23'h0};
      endcase
   end

   assign op_req     = port_ready && (cmd_kind != FOP_IDLE) && !(checking && sr_ready);
   assign op_kind    = op_req ? flash_op_t'(cmd_kind) : FOP_IDLE;
   assign op_addr    = op_req ? cmd_addr : '0;
   assign op_wdata   = op_req ? cmd_wdata : '0;
   assign phase_code = (state inside {[AS_PROG_CMD:AS_PROG_CHECK]}) ? ST_WRITING :
                       (state inside {[AS_READ_CMD:AS_READ_WORD]}) ? ST_READING : ST_RESET;

   always_ff @(posedge clock)
   begin
      access_done <= 1'b0;
      if (reset)
      begin
         state <= AS_IDLE;
         wptr  <= '0;
      end
      else if (erase_done)
         wptr <= '0;                           // Fresh array after init
      else if (state == AS_IDLE)
      begin
         if (write_start)
         begin
            state  <= AS_PROG_CMD;
            data_q <= datain;
         end
         else if (read_start)
            state <= read_armed ? AS_READ_WORD : AS_READ_CMD;
      end
      else if (fail)
         state <= AS_ERROR;
      else if (port_ready && !hold && (state != AS_ERROR))
      begin
         if (checking)
         begin
            state       <= AS_IDLE;
            wptr        <= wptr + 1'b1;
            access_done <= 1'b1;
         end
         else if (state == AS_READ_WORD)
         begin
            state       <= AS_IDLE;            // Data shows up once port is ready
            access_done <= 1'b1;
         end
         else
            state <= access_state_t'(state + 1'b1);
      end
   end

endmodule

`default_nettype wire

// File: verilog/flash_cmd_port.sv
`default_nettype none

module flash_cmd_port
(
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          op_req,
   input  flash_tester_pkg::flash_op_t   op_kind,
   input  flash_tester_pkg::flash_addr_t op_addr,
   input  flash_tester_pkg::flash_data_t op_wdata,
   input  logic                          fbusy,
   output flash_tester_pkg::flash_op_t   fop,
   output flash_tester_pkg::flash_addr_t faddress,
   output flash_tester_pkg::flash_data_t fwdata,
   output logic                          port_ready
);

   import flash_tester_pkg::*;

   // Free only with the flash idle and nothing on the strobe
   assign port_ready = !fbusy && (fop == FOP_IDLE);

   ////////////////////////////////////////
   // One-cycle op strobe per request
   ////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
         fop <= FOP_IDLE;
      else if (op_req)
         fop <= op_kind;
      else
         fop <= FOP_IDLE;
   end

   // Address and data hold after the strobe
   always_ff @(posedge clock)
   begin
      if (op_req)
      begin
         faddress <= op_addr;
         fwdata   <= op_wdata;
      end
   end

   a_op_handshake: assert property (@(posedge clock) disable iff (reset)
      op_req |-> port_ready);

endmodule

`default_nettype wire

// File: verilog/flash_tester_pkg.sv
`default_nettype none

package flash_tester_pkg;

   ////////////////////////////////////////
   // Flash command bus
   ////////////////////////////////////////

   localparam int ADDR_W = 23;                 // Word address of a 128 Mbit part
   localparam int DATA_W = 16;

   typedef logic [ADDR_W-1:0] flash_addr_t;
   typedef logic [DATA_W-1:0] flash_data_t;

   typedef enum logic [1:0]
   {
      FOP_IDLE  = 2'b00,
      FOP_READ  = 2'b01,
      FOP_WRITE = 2'b10
   } flash_op_t;

   ////////////////////////////////////////
   // Tester modes and status codes
   ////////////////////////////////////////

   typedef enum logic [1:0]
   {
      MODE_IDLE  = 2'd0,
      MODE_INIT  = 2'd1,
      MODE_WRITE = 2'd2,
      MODE_READ  = 2'd3
   } mode_t;

   typedef enum logic [3:0]
   {
      ST_RESET             = 4'h0,
      ST_READ_ID           = 4'h1,
      ST_CLEAR_LOCKS       = 4'h2,
      ST_ERASING           = 4'h3,
      ST_WRITING           = 4'h4,
      ST_READING           = 4'h5,
      ST_BAD_MANUFACTURER  = 4'h7,
      ST_BAD_SIZE          = 4'h8,
      ST_LOCK_BIT_ERROR    = 4'h9,
      ST_ERASE_BLOCK_ERROR = 4'hA,
      ST_WRITE_ERROR       = 4'hB
   } status_t;

   ////////////////////////////////////////
   // Flash command set
   ////////////////////////////////////////

   localparam flash_data_t CMD_READ_ID     = 16'h0090;
   localparam flash_data_t CMD_READ_ARRAY  = 16'h00FF;
   localparam flash_data_t CMD_CLEAR_LOCKS = 16'h0060;
   localparam flash_data_t CMD_CONFIRM     = 16'h00D0;   // Shared by lock clear and erase
   localparam flash_data_t CMD_ERASE       = 16'h0020;
   localparam flash_data_t CMD_PROGRAM     = 16'h0040;

   localparam flash_data_t ID_MANUFACTURER = 16'h0089;
   localparam flash_data_t ID_DEVICE_SIZE  = 16'h0018;   // 128 Mbit

   localparam flash_addr_t BLOCK_SIZE      = 23'h01_0000; // 64K words
   localparam flash_addr_t ERASE_LAST_ADDR = 23'h20_0000;
   localparam flash_addr_t LAST_ADDR       = 23'h7F_FFFF;

   localparam int SR_READY_BIT = 7;            // Internal write machine idle
   localparam int SR_ERR_HI    = 6;
   localparam int SR_ERR_LO    = 1;

endpackage

`default_nettype wire

// File: verilog/flash_tester_top.sv
`default_nettype none

module flash_tester_top
(
   input  logic                          clock,
   input  logic                          reset,
   input  flash_tester_pkg::mode_t       mode,
   input  flash_tester_pkg::flash_data_t datain,
   input  flash_tester_pkg::flash_addr_t addrin,
   input  logic                          fbusy,
   input  flash_tester_pkg::flash_data_t frdata,
   output flash_tester_pkg::flash_op_t   fop,
   output flash_tester_pkg::flash_addr_t faddress,
   output flash_tester_pkg::flash_data_t fwdata,
   output logic                          busy,
   output flash_tester_pkg::status_t     status
);

   import flash_tester_pkg::*;

   logic        init_start;
   logic        write_start;
   logic        read_start;
   logic        read_armed;
   logic        init_done;
   logic        erase_done;
   logic        access_done;
   logic        port_ready;

   logic        init_req;
   flash_op_t   init_kind;
   flash_addr_t init_addr;
   flash_data_t init_wdata;
   status_t     init_phase;
   logic        init_error;
   status_t     init_err_code;

   logic        acc_req;
   flash_op_t   acc_kind;
   flash_addr_t acc_addr;
   flash_data_t acc_wdata;
   status_t     acc_phase;
   logic        acc_error;
   status_t     acc_err_code;

   logic        op_req;
   flash_op_t   op_kind;
   flash_addr_t op_addr;
   flash_data_t op_wdata;
   status_t     phase_code;
   logic        seq_error;
   status_t     err_code;

   // Idle sequencer drives all zeros, so OR merges the two
   assign op_req     = init_req | acc_req;
   assign op_kind    = flash_op_t'(init_kind | acc_kind);
   assign op_addr    = init_addr | acc_addr;
   assign op_wdata   = init_wdata | acc_wdata;
   assign phase_code = status_t'(init_phase | acc_phase);
   assign seq_error  = init_error | acc_error;
   assign err_code   = status_t'(init_err_code | acc_err_code);

   mode_control u_mode_control
   (
      .clock       (clock),
      .reset       (reset),
      .mode        (mode),
      .port_ready  (port_ready),
      .init_done   (init_done),
      .access_done (access_done),
      .seq_error   (seq_error),
      .err_code    (err_code),
      .phase_code  (phase_code),
      .init_start  (init_start),
      .write_start (write_start),
      .read_start  (read_start),
      .read_armed  (read_armed),
      .busy        (busy),
      .status      (status)
   );

   init_sequencer u_init_sequencer
   (
      .clock      (clock),
      .reset      (reset),
      .init_start (init_start),
      .port_ready (port_ready),
      .frdata     (frdata),
      .op_req     (init_req),
      .op_kind    (init_kind),
      .op_addr    (init_addr),
      .op_wdata   (init_wdata),
      .phase_code (init_phase),
      .init_done  (init_done),
      .erase_done (erase_done),
      .seq_error  (init_error),
      .err_code   (init_err_code)
   );

   access_sequencer u_access_sequencer
   (
      .clock       (clock),
      .reset       (reset),
      .write_start (write_start),
      .read_start  (read_start),
      .read_armed  (read_armed),
      .erase_done  (erase_done),
      .port_ready  (port_ready),
      .datain      (datain),
      .addrin      (addrin),
      .frdata      (frdata),
      .op_req      (acc_req),
      .op_kind     (acc_kind),
      .op_addr     (acc_addr),
      .op_wdata    (acc_wdata),
      .phase_code  (acc_phase),
      .access_done (access_done),
      .seq_error   (acc_error),
      .err_code    (acc_err_code)
   );

   flash_cmd_port u_flash_cmd_port
   (
      .clock      (clock),
      .reset      (reset),
      .op_req     (op_req),
      .op_kind    (op_kind),
      .op_addr    (op_addr),
      .op_wdata   (op_wdata),
      .fbusy      (fbusy),
      .fop        (fop),
      .faddress   (faddress),
      .fwdata     (fwdata),
      .port_ready (port_ready)
   );

endmodule

`default_nettype wire

// File: verilog/init_sequencer.sv
`default_nettype none

module init_sequencer
(
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          init_start,
   input  logic                          port_ready,
   input  flash_tester_pkg::flash_data_t frdata,
   output logic                          op_req,
   output flash_tester_pkg::flash_op_t   op_kind,
   output flash_tester_pkg::flash_addr_t op_addr,
   output flash_tester_pkg::flash_data_t op_wdata,
   output flash_tester_pkg::status_t     phase_code,
   output logic                          init_done,
   output logic                          erase_done,
   output logic                          seq_error,
   output flash_tester_pkg::status_t     err_code
);

   import flash_tester_pkg::*;

   // Most states simply step to the next one in this order
   typedef enum logic [3:0]
   {
      IS_IDLE, IS_ID_CMD, IS_ID_MFR, IS_ID_SIZE, IS_ARRAY,
      IS_LOCK_CMD, IS_LOCK_CONF, IS_LOCK_POLL, IS_LOCK_CHECK,
      IS_ERASE_CMD, IS_ERASE_CONF, IS_ERASE_POLL, IS_ERASE_CHECK,
      IS_ERROR
   } init_state_t;

   init_state_t state;
   flash_addr_t erase_addr;
   logic [1:0]  cmd_kind;
   flash_data_t cmd_wdata;
   flash_addr_t cmd_addr;
   logic        sr_ready;
   logic        sr_error;
   logic        poll_state;
   logic        erase_phase;
   logic        id_bad;
   logic        hold;
   logic        fail;

   assign sr_ready    = frdata[SR_READY_BIT];
   assign sr_error    = |frdata[SR_ERR_HI:SR_ERR_LO];
   assign poll_state  = (state == IS_LOCK_CHECK) || (state == IS_ERASE_CHECK);
   assign erase_phase = state inside {[IS_ERASE_CMD:IS_ERASE_CHECK]};
   assign id_bad      = ((state == IS_ID_SIZE) && (frdata != ID_MANUFACTURER)) ||
                        ((state == IS_ARRAY) && (frdata != ID_DEVICE_SIZE));
   assign hold        = poll_state && !sr_ready;      // Poll again while status is not ready
   assign fail        = port_ready && (id_bad || (poll_state && sr_ready && sr_error));
   assign seq_error   = (state == IS_ERROR);
   assign erase_done  = init_done;

   ////////////////////////////////////////
   // Op of each state
   ////////////////////////////////////////

   always_comb
   begin
      case (state)
         IS_ID_CMD:     {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_READ_ID, 23'h0};
         IS_ID_MFR:     {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, 23'h0};
         IS_ID_SIZE:    {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, 23'h1};
         IS_ARRAY:      {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_READ_ARRAY, 23'h0};
         IS_LOCK_CMD:   {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_CLEAR_LOCKS, 23'h0};
         IS_LOCK_CONF:  {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_CONFIRM, 23'h0};
         IS_LOCK_POLL,
         IS_LOCK_CHECK: {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, 23'h0};
         IS_ERASE_CMD:  {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_ERASE, erase_addr};
         IS_ERASE_CONF: {cmd_kind, cmd_wdata, cmd_addr} = {FOP_WRITE, CMD_CONFIRM, erase_addr};
         IS_ERASE_POLL,
         IS_ERASE_CHECK: {cmd_kind, cmd_wdata, cmd_addr} = {FOP_READ, 16'h0, erase_addr};
         default:       {cmd_kind, cmd_wdata, cmd_addr} = {FOP_IDLE, 16'h0, 23'h0};
      endcase
   end

   // Checks gate the op and outputs stay zero when not issuing
   assign op_req   = port_ready && (cmd_kind != FOP_IDLE) && !id_bad &&
                     !(poll_state && sr_ready);
   assign op_kind  = op_req ? flash_op_t'(cmd_kind) : FOP_IDLE;
   assign op_addr  = op_req ? cmd_addr : '0;
   assign op_wdata = op_req ? cmd_wdata : '0;

   always_comb
   begin
      if (state inside {[IS_ID_CMD:IS_ARRAY]})
         phase_code = ST_READ_ID;
      else if (state inside {[IS_LOCK_CMD:IS_LOCK_CHECK]})
         phase_code = ST_CLEAR_LOCKS;
      else if (erase_phase)
         phase_code = ST_ERASING;
      else
         phase_code = ST_RESET;
   end

   always_ff @(posedge clock)
   begin
      init_done <= 1'b0;
      if (reset)
      begin
         state    <= IS_IDLE;
         err_code <= ST_RESET;
      end
      else if (state == IS_IDLE)
      begin
         if (init_start)
         begin
            state      <= IS_ID_CMD;
            erase_addr <= '0;
         end
      end
      else if (fail)
      begin
         state <= IS_ERROR;
         case (state)
            IS_ID_SIZE:    err_code <= ST_BAD_MANUFACTURER;
            IS_ARRAY:      err_code <= ST_BAD_SIZE;
            IS_LOCK_CHECK: err_code <= ST_LOCK_BIT_ERROR;
            default:       err_code <= ST_ERASE_BLOCK_ERROR;
         endcase
      end
      else if (port_ready && !hold && (state != IS_ERROR))
      begin
         if (state != IS_ERASE_CHECK)
            state <= init_state_t'(state + 1'b1);
         else if (erase_addr != ERASE_LAST_ADDR)
         begin
            state      <= IS_ERASE_CMD;        // Next block
            erase_addr <= erase_addr + BLOCK_SIZE;
         end
         else
         begin
            state     <= IS_IDLE;
            init_done <= 1'b1;
         end
      end
   end

   a_erase_aligned: assert property (@(posedge clock) disable iff (reset)
      (op_req && erase_phase)
         |-> ((op_addr % BLOCK_SIZE) == '0) && (op_addr <= ERASE_LAST_ADDR));

endmodule

`default_nettype wire

// File: verilog/mode_control.sv
`default_nettype none

module mode_control
(
   input  logic                      clock,
   input  logic                      reset,
   input  flash_tester_pkg::mode_t   mode,
   input  logic                      port_ready,
   input  logic                      init_done,
   input  logic                      access_done,
   input  logic                      seq_error,
   input  flash_tester_pkg::status_t err_code,
   input  flash_tester_pkg::status_t phase_code,
   output logic                      init_start,
   output logic                      write_start,
   output logic                      read_start,
   output logic                      read_armed,
   output logic                      busy,
   output flash_tester_pkg::status_t status
);

   import flash_tester_pkg::*;

   typedef enum logic [1:0]
   {
      MC_HOME,
      MC_ACTIVE,
      MC_HALT
   } mc_state_t;

   mc_state_t state;

   // Array mode already entered by an earlier read
   assign read_armed = (status == ST_READING);

   always_ff @(posedge clock)
   begin
      init_start  <= 1'b0;
      write_start <= 1'b0;
      read_start  <= 1'b0;
      if (reset)
      begin
         state  <= MC_HOME;
         busy   <= 1'b1;
         status <= ST_RESET;
      end
      else
      begin
         case (state)
            MC_HOME:
               if (port_ready)
               begin
                  busy  <= (mode != MODE_IDLE);
                  state <= (mode != MODE_IDLE) ? MC_ACTIVE : MC_HOME;
                  case (mode)
                     MODE_INIT:  init_start  <= 1'b1;
                     MODE_WRITE: write_start <= 1'b1;
                     MODE_READ:  read_start  <= 1'b1;
                     MODE_IDLE:  busy        <= 1'b0;
                  endcase
               end
            MC_ACTIVE:
               if (seq_error)
               begin
                  status <= err_code;          // Sticky until reset
                  state  <= MC_HALT;
               end
               else
               begin
                  if (phase_code != ST_RESET)
                     status <= phase_code;
                  if (init_done || access_done)
                     state <= MC_HOME;
               end
            default:
               state <= MC_HALT;               // Stopped with busy held high
         endcase
      end
   end

   a_single_start: assert property (@(posedge clock) disable iff (reset)
      $onehot0({init_start, write_start, read_start}));

endmodule

`default_nettype wire
